//--- Bender.yml
package:
  name: thor_decode_unit

sources:
  - isaPkg.sv
  - decodePkg.sv
  - decodeRegs.sv
  - decodeImm.sv
  - decodeClass.sv
  - decodeCtrl.sv
  - thorDecodeUnit.sv
  - target: test
    files:
      - thorDecodeUnitTb.sv

//--- decodeClass.sv
/*
 * Instruction class decoder
 * Sets one class flag per opcode and flags undefined encodings
 */
`timescale 1ns/1ns
`default_nettype none

module decodeClass import isaPkg::*, decodePkg::*;
(
	input wire clk,
	input wire reset,
	input wire instruction_t instr,
	output insnClass_t cls
);

	always_comb
	begin
		cls = '0;
		case (instr.opcode)
			// A NOP is treated as an ALU operation with no effect
			OP_NOP, OP_ADD, OP_ADDI:
				cls.isAlu = 1'b1;
			OP_LOAD:
				cls.isLoad = 1'b1;
			OP_STORE:
				cls.isStore = 1'b1;
			// Both conditional branches share the branch unit
			OP_BEQ, OP_DBRA:
				cls.isBranch = 1'b1;
			OP_RTD:
				cls.isReturn = 1'b1;
			// Anything else traps as an illegal instruction
			default:
				cls.illegal = 1'b1;
		endcase
	end

	// The host reads the flags as one word, so no opcode may set two of them
	// or leave all of them clear, whatever the controller has latched
	classOneHot: assert property (
		@(posedge clk) disable iff (reset)
		$onehot(cls)
	) else $error("class flags are not one-hot: %b", cls);

endmodule

`default_nettype wire

//--- decodeCtrl.sv
/*
 * Decode controller with APB slave
 * Holds the instruction register, sequences one decode at a time,
 * captures the decoder outputs and serves the result registers
 */
`timescale 1ns/1ns
`default_nettype none

module decodeCtrl import isaPkg::*, decodePkg::*;
#(
	parameter int ImmWidth = 32
)
(
	input wire clk,
	input wire reset,
	input wire apbAddr_t paddr,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire apbData_t pwdata,
	output apbData_t prdata,
	output logic pready,
	output logic pslverr,
	output instruction_t instr,
	input wire regspec_t ra,
	input wire regspec_t rb,
	input wire regspec_t rt,
	input wire [ImmWidth-1:0] imm,
	input wire insnClass_t cls
);

	ctrlState_t state;
	instruction_t instrReg;
	decoded_t result;
	logic [ImmWidth-1:0] immReg;
	logic busy;
	logic valid;
	logic access;
	logic mapped;
	logic resultAddr;
	logic badAccess;
	logic stall;
	logic insnWrite;

	// ======================================================================
	// APB access decode
	// ======================================================================
	assign access = psel & penable;
	assign mapped = paddr inside {ADDR_INSN, ADDR_STATUS, ADDR_REGS, ADDR_IMM, ADDR_CLASS};
	assign resultAddr = paddr inside {ADDR_REGS, ADDR_IMM, ADDR_CLASS};

	// Only the instruction register may be written
	assign badAccess = !mapped | (pwrite & (paddr != ADDR_INSN));

	// A result read or a new instruction has to wait out the decode cycle
	assign stall = busy & ((pwrite & (paddr == ADDR_INSN)) | (!pwrite & resultAddr));

	// Transfer completes on this edge
	assign insnWrite = access & pready & pwrite & (paddr == ADDR_INSN);

	// One wait state per transfer, more while the decoder is busy
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pready <= 1'b0;
			pslverr <= 1'b0;
		end
		else if (access && !pready && !stall)
		begin
			pready <= 1'b1;
			pslverr <= badAccess;
		end
		else
		begin
			pready <= 1'b0;
			pslverr <= 1'b0;
		end
	end

	// ======================================================================
	// Sequencing
	// ======================================================================
	always_ff @(posedge clk)
	begin
		if (reset)
			state <= ST_IDLE;
		else
		begin
			case (state)
				ST_IDLE, ST_DONE:
					if (insnWrite)
						state <= ST_DECODE;
				// Decoders are combinational, one cycle is enough
				ST_DECODE:
					state <= ST_DONE;
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	assign busy = (state == ST_DECODE);
	assign valid = (state == ST_DONE);

	// Instruction register starts as a NOP so the decoders see a legal word
	always_ff @(posedge clk)
	begin
		if (reset)
			instrReg <= '0;
		else if (insnWrite)
			instrReg <= pwdata;
	end

	assign instr = instrReg;

	// Results are sampled once, at the end of the decode cycle
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			result <= '0;
			immReg <= '0;
		end
		else if (state == ST_DECODE)
		begin
			result <= '{ra: ra, rb: rb, rt: rt, cls: cls};
			immReg <= imm;
		end
	end

	// ======================================================================
	// Read data
	// ======================================================================
	always_comb
	begin
		prdata = '0;
		case (paddr)
			ADDR_STATUS:
			begin
				prdata[STATUS_BUSY] = busy;
				prdata[STATUS_VALID] = valid;
			end
			ADDR_REGS:
			begin
				prdata[REGS_RA_LSB +: REG_W] = result.ra;
				prdata[REGS_RB_LSB +: REG_W] = result.rb;
				prdata[REGS_RT_LSB +: REG_W] = result.rt;
			end
			// A narrow immediate is widened with its sign
			ADDR_IMM:
				prdata = apbData_t'($signed(immReg));
			ADDR_CLASS:
				prdata[$bits(insnClass_t)-1:0] = result.cls;
			// Instruction register is write only and reads as zero
			default:
				prdata = '0;
		endcase
	end

	// The host must keep the access phase up until the slave answers
	readyInAccess: assert property (
		@(posedge clk) disable iff (reset)
		pready |-> (psel && penable)
	) else $error("pready high outside an access phase");

	// No new instruction slips in during decode, and decode ends after one cycle
	decodeOneCycle: assert property (
		@(posedge clk) disable iff (reset)
		(state == ST_DECODE) |-> !insnWrite ##1 (state == ST_DONE)
	) else $error("decode cycle was not exactly one clock");

endmodule

`default_nettype wire

//--- decodeImm.sv
/*
 * Immediate extractor
 * Produces the sign- or zero-extended constant for each immediate form
 */
`timescale 1ns/1ns
`default_nettype none

module decodeImm import isaPkg::*;
#(
	parameter int ImmWidth = 32
)
(
	input wire instruction_t instr,
	output logic [ImmWidth-1:0] imm
);

	instrImm_t immView;

	// Look at the upper 13 bits as a single field
	assign immView = instrImm_t'(instr);

	always_comb
	begin
		case (instr.opcode)
			// ======================================================
			// 13-bit signed offset or constant
			// ======================================================
			OP_ADDI, OP_LOAD, OP_STORE:
				imm = ImmWidth'($signed(immView.imm));

			// Branch displacement counts instructions, hence the shift by 2
			OP_BEQ, OP_DBRA:
				imm = ImmWidth'($signed({instr.func, 2'b00}));

			// Stack adjustment is unsigned and counted in 8-byte words
			OP_RTD:
				imm = ImmWidth'({immView.imm, 3'b000});

			// No immediate in the remaining forms
			default:
				imm = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- decodePkg.sv
/*
 * Decode result and host interface definitions
 * Holds the decoded bundle, the class flags, the APB register map
 * and the states of the controller
 */
`default_nettype none

package decodePkg;
	import isaPkg::*;

	// Exactly one flag is set per instruction
	typedef struct packed {
		logic isAlu;
		logic isLoad;
		logic isStore;
		logic isBranch;
		logic isReturn;
		logic illegal;
	} insnClass_t;

	// Captured result, 24 bits in all
	typedef struct packed {
		regspec_t ra;
		regspec_t rb;
		regspec_t rt;
		insnClass_t cls;
	} decoded_t;

	typedef logic [7:0] apbAddr_t;
	typedef logic [31:0] apbData_t;

	// ======================================================================
	// APB register map
	// ======================================================================
	localparam apbAddr_t ADDR_INSN = 8'h00;
	localparam apbAddr_t ADDR_STATUS = 8'h04;
	localparam apbAddr_t ADDR_REGS = 8'h08;
	localparam apbAddr_t ADDR_IMM = 8'h0C;
	localparam apbAddr_t ADDR_CLASS = 8'h10;

	// Bit positions inside the status and register words
	localparam int STATUS_BUSY = 0;
	localparam int STATUS_VALID = 1;
	localparam int REGS_RA_LSB = 0;
	localparam int REGS_RB_LSB = 8;
	localparam int REGS_RT_LSB = 16;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_DECODE,
		ST_DONE
	} ctrlState_t;

endpackage

`default_nettype wire

//--- decodeRegs.sv
/*
 * Register specifier decoder
 * Picks source A, source B and target, with fixed registers for
 * the opcodes that work on the stack pointer or loop counter
 */
`timescale 1ns/1ns
`default_nettype none

module decodeRegs import isaPkg::*;
(
	input wire instruction_t instr,
	output regspec_t ra,
	output regspec_t rb,
	output regspec_t rt
);

	// Source A comes from the ra field unless the opcode implies a register
	always_comb
	begin
		case (instr.opcode)
			// Return and deallocate pops through the stack pointer
			OP_RTD:  ra = REG_SP;
			// Decrement and branch tests the loop counter
			OP_DBRA: ra = REG_LC;
			default: ra = instr.ra;
		endcase
	end

	// Only the two-register forms read a second source
	always_comb
	begin
		case (instr.opcode)
			OP_ADD, OP_STORE, OP_BEQ: rb = instr.rb;
			default: rb = REG_ZERO;
		endcase
	end

	// Both counter opcodes write back the register they read
	always_comb
	begin
		case (instr.opcode)
			OP_DBRA: rt = REG_LC;
			OP_RTD:  rt = REG_SP;
			// Stores and compares write nothing, so they target r0
			OP_STORE, OP_BEQ: rt = REG_ZERO;
			default: rt = instr.rt;
		endcase
	end

endmodule

`default_nettype wire

//--- isaPkg.sv
/*
 * Instruction set definitions for the decode unit
 * Covers the 32-bit instruction format, the opcode set and the
 * architectural registers that some opcodes name implicitly
 */
`default_nettype none

package isaPkg;

	// Field widths of the instruction word
	localparam int OPCODE_W = 7;
	localparam int REG_W = 6;
	localparam int FUNC_W = 7;
	localparam int IMM_FIELD_W = 13;

	// One of the 64 architectural registers
	typedef logic [REG_W-1:0] regspec_t;

	// Any encoding not listed here is an illegal instruction
	typedef enum logic [OPCODE_W-1:0] {
		OP_NOP   = 7'd0,
		OP_ADD   = 7'd2,
		OP_ADDI  = 7'd4,
		OP_LOAD  = 7'd8,
		OP_STORE = 7'd9,
		OP_BEQ   = 7'd16,
		OP_DBRA  = 7'd17,
		OP_RTD   = 7'd20
	} opcode_t;

	// Register format, most significant field first
	typedef struct packed {
		logic [FUNC_W-1:0] func;
		regspec_t rb;
		regspec_t ra;
		regspec_t rt;
		opcode_t opcode;
	} instruction_t;

	// Same 32 bits seen as immediate forms, where func and rb merge into one field
	typedef struct packed {
		logic [IMM_FIELD_W-1:0] imm;
		logic [31-IMM_FIELD_W:0] lower;
	} instrImm_t;

	// Registers with a fixed role
	localparam regspec_t REG_ZERO = 6'd0;
	localparam regspec_t REG_LC = 6'd55;
	localparam regspec_t REG_SP = 6'd62;

endpackage

`default_nettype wire

//--- thorDecodeUnit.f
isaPkg.sv
decodePkg.sv
decodeRegs.sv
decodeImm.sv
decodeClass.sv
decodeCtrl.sv
thorDecodeUnit.sv
thorDecodeUnitTb.sv

//--- thorDecodeUnit.sv
/*
 * Instruction decode unit, top level
 * Connects the APB controller to the register, immediate and class decoders
 */
`timescale 1ns/1ns
`default_nettype none

module thorDecodeUnit import isaPkg::*, decodePkg::*;
#(
	parameter int ImmWidth = 32
)
(
	input wire clk,
	input wire reset,
	input wire apbAddr_t paddr,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire apbData_t pwdata,
	output apbData_t prdata,
	output logic pready,
	output logic pslverr
);

	// Latched instruction fans out to all three decoders
	instruction_t instr;
	regspec_t ra;
	regspec_t rb;
	regspec_t rt;
	logic [ImmWidth-1:0] imm;
	insnClass_t cls;

	decodeCtrl #(
		.ImmWidth(ImmWidth)
	) ctrl (
		.clk(clk),
		.reset(reset),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.instr(instr),
		.ra(ra),
		.rb(rb),
		.rt(rt),
		.imm(imm),
		.cls(cls)
	);

	decodeRegs regs (
		.instr(instr),
		.ra(ra),
		.rb(rb),
		.rt(rt)
	);

	decodeImm #(
		.ImmWidth(ImmWidth)
	) immDec (
		.instr(instr),
		.imm(imm)
	);

	// Clock and reset only drive the class check
	decodeClass classDec (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.cls(cls)
	);

endmodule

`default_nettype wire

//--- thorDecodeUnitTb.sv
/*
 * Testbench for the instruction decode unit
 * Writes instruction words over APB, reads the decoded fields back and
 * compares them with a reference decode built from the ISA rules
 */
`timescale 1ns/1ns
`default_nettype none

module thorDecodeUnitTb import isaPkg::*, decodePkg::*;
();

	// Cycles any handshake may take before the run is abandoned
	localparam int TIMEOUT = 20;
	// One regular wait state plus at most two stall cycles
	localparam int MAX_WAITS = 3;

	typedef struct packed {
		apbAddr_t addr;
		apbData_t got;
		apbData_t exp;
	} readRec_t;

	logic clk;
	logic reset;
	apbAddr_t paddr;
	logic psel;
	logic penable;
	logic pwrite;
	apbData_t pwdata;
	apbData_t prdata;
	logic pready;
	logic pslverr;

	integer seed;
	int errorCount;
	int checkCount;
	int testCount;
	int errorsAtStart;
	readRec_t pending[$];
	readRec_t rec;
	opcode_t legalOps[8] = '{OP_NOP, OP_ADD, OP_ADDI, OP_LOAD, OP_STORE, OP_BEQ, OP_DBRA, OP_RTD};

	thorDecodeUnit #(
		.ImmWidth(32)
	) uut (
		.clk(clk),
		.reset(reset),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	always #50 clk = ~clk;

	// ======================================================================
	// Reference decode
	// ======================================================================
	function automatic decoded_t refDecode(input apbData_t word, output apbData_t imm);
		decoded_t d;
		apbData_t simm13;
		apbData_t disp;
		d = '0;
		d.ra = word[18:13];
		d.rt = word[12:7];
		imm = '0;
		// 13-bit signed field and the word-scaled 7-bit branch displacement
		simm13 = {{19{word[31]}}, word[31:19]};
		disp = {{23{word[31]}}, word[31:25], 2'b00};
		case (word[6:0])
			OP_NOP:
				d.cls.isAlu = 1'b1;
			OP_ADD:
			begin
				d.cls.isAlu = 1'b1;
				d.rb = word[24:19];
			end
			OP_ADDI:
			begin
				d.cls.isAlu = 1'b1;
				imm = simm13;
			end
			OP_LOAD:
			begin
				d.cls.isLoad = 1'b1;
				imm = simm13;
			end
			OP_STORE:
			begin
				d.cls.isStore = 1'b1;
				d.rb = word[24:19];
				d.rt = REG_ZERO;
				imm = simm13;
			end
			OP_BEQ:
			begin
				d.cls.isBranch = 1'b1;
				d.rb = word[24:19];
				d.rt = REG_ZERO;
				imm = disp;
			end
			// Loop counter is both source and target, whatever bits 18 to 13 hold
			OP_DBRA:
			begin
				d.cls.isBranch = 1'b1;
				d.ra = REG_LC;
				d.rt = REG_LC;
				imm = disp;
			end
			// Stack adjustment counts 8-byte units and is never negative
			OP_RTD:
			begin
				d.cls.isReturn = 1'b1;
				d.ra = REG_SP;
				d.rt = REG_SP;
				imm = {16'b0, word[31:19], 3'b000};
			end
			default:
				d.cls.illegal = 1'b1;
		endcase
		return d;
	endfunction

	// Layout of the ADDR_REGS word
	function automatic apbData_t regsWord(input decoded_t d);
		apbData_t w;
		w = '0;
		w[5:0] = d.ra;
		w[13:8] = d.rb;
		w[21:16] = d.rt;
		return w;
	endfunction

	function automatic bit isLegal(input logic [6:0] op);
		return op inside {OP_NOP, OP_ADD, OP_ADDI, OP_LOAD, OP_STORE, OP_BEQ, OP_DBRA, OP_RTD};
	endfunction

	// ======================================================================
	// Compare tasks and compare process
	// ======================================================================
	task automatic checkRegs(input regspec_t gotRa, gotRb, gotRt, expRa, expRb, expRt);
		checkCount++;
		if ({gotRa, gotRb, gotRt} !== {expRa, expRb, expRt})
		begin
			$display("CHECK FAILED ra/rb/rt: got %h %h %h expected %h %h %h",
				gotRa, gotRb, gotRt, expRa, expRb, expRt);
			errorCount++;
		end
	endtask

	task automatic checkImm(input apbData_t got, input apbData_t exp);
		checkCount++;
		if (got !== exp)
		begin
			$display("CHECK FAILED imm: got %h expected %h", got, exp);
			errorCount++;
		end
	endtask

	task automatic checkClass(input insnClass_t got, input insnClass_t exp);
		checkCount++;
		if (got !== exp)
		begin
			$display("CHECK FAILED cls: got %h expected %h", got, exp);
			errorCount++;
		end
	endtask

	task automatic checkStatus(input logic [1:0] got, input logic [1:0] exp);
		checkCount++;
		if (got !== exp)
		begin
			$display("CHECK FAILED status: got %h expected %h", got, exp);
			errorCount++;
		end
	endtask

	// Every read lands in the queue and is checked here, by register
	always @(negedge clk)
	begin
		while (pending.size() > 0)
		begin
			rec = pending.pop_front();
			case (rec.addr)
				ADDR_STATUS:
					checkStatus(rec.got[1:0], rec.exp[1:0]);
				ADDR_REGS:
					checkRegs(rec.got[5:0], rec.got[13:8], rec.got[21:16],
						rec.exp[5:0], rec.exp[13:8], rec.exp[21:16]);
				ADDR_IMM:
					checkImm(rec.got, rec.exp);
				ADDR_CLASS:
					checkClass(rec.got[5:0], rec.exp[5:0]);
				default:
				begin
					$display("no compare rule for a read of address %h", rec.addr);
					errorCount++;
				end
			endcase
		end
	end

	// ======================================================================
	// APB driver
	// ======================================================================
	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Something failed");
		$finish;
	endtask

	// Polls pready once per cycle until the slave answers
	task automatic waitReady(output int waits);
		waits = 0;
		do
		begin
			@(negedge clk);
			waits++;
		end
		while (!pready && waits < TIMEOUT);
		if (!pready)
			abortRun($sformatf("no pready for address %h within %0d cycles", paddr, TIMEOUT));
	endtask

	task automatic apbWrite(input apbAddr_t addr, input apbData_t data, output logic err,
		output int waits);
		@(negedge clk);
		paddr = addr;
		pwdata = data;
		pwrite = 1'b1;
		psel = 1'b1;
		penable = 1'b0;
		@(negedge clk);
		penable = 1'b1;
		waitReady(waits);
		err = pslverr;
		// Transfer completes on this edge
		@(posedge clk);
	endtask

	task automatic apbRead(input apbAddr_t addr, output apbData_t data, output logic err,
		output int waits);
		@(negedge clk);
		paddr = addr;
		pwrite = 1'b0;
		psel = 1'b1;
		penable = 1'b0;
		@(negedge clk);
		penable = 1'b1;
		waitReady(waits);
		data = prdata;
		err = pslverr;
		@(posedge clk);
	endtask

	task automatic apbIdle();
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic readAndPost(input apbAddr_t addr, input apbData_t exp, output int waits);
		apbData_t data;
		logic err;
		readRec_t r;
		apbRead(addr, data, err, waits);
		if (err)
		begin
			$display("read of address %h returned an error response", addr);
			errorCount++;
		end
		r.addr = addr;
		r.got = data;
		r.exp = exp;
		pending.push_back(r);
	endtask

	// Write one word, then read every result right behind it
	task automatic decodeOne(input apbData_t word);
		decoded_t expDec;
		apbData_t expImm;
		logic err;
		int waits;
		expDec = refDecode(word, expImm);
		apbWrite(ADDR_INSN, word, err, waits);
		if (err || waits > MAX_WAITS)
		begin
			$display("write of instruction %h failed or stalled %0d cycles", word, waits);
			errorCount++;
		end
		readAndPost(ADDR_REGS, regsWord(expDec), waits);
		if (waits > MAX_WAITS)
		begin
			$display("register read after write stalled %0d cycles", waits);
			errorCount++;
		end
		readAndPost(ADDR_IMM, expImm, waits);
		readAndPost(ADDR_CLASS, apbData_t'(expDec.cls), waits);
		// Valid set and busy clear
		readAndPost(ADDR_STATUS, 32'h0000_0002, waits);
	endtask

	task automatic expectError(input apbAddr_t addr, input logic write);
		apbData_t data;
		logic err;
		int waits;
		if (write)
			apbWrite(addr, 32'h1, err, waits);
		else
			apbRead(addr, data, err, waits);
		if (!err)
		begin
			$display("%s of address %h completed without an error response",
				write ? "write" : "read", addr);
			errorCount++;
		end
	endtask

	task automatic finishTest(input string name);
		int waited;
		apbIdle();
		waited = 0;
		while (pending.size() != 0 && waited < TIMEOUT)
		begin
			@(negedge clk);
			waited++;
		end
		if (pending.size() != 0)
		begin
			$display("compare queue did not drain within %0d cycles", TIMEOUT);
			errorCount++;
		end
		testCount++;
		$display("test %s %s", name, errorCount == errorsAtStart ? "passed" : "FAILED");
		errorsAtStart = errorCount;
	endtask

	// ======================================================================
	// Stimulus
	// ======================================================================
	initial
	begin
		apbData_t word;
		logic [6:0] op;
		int waits;
		seed = 80095;
		errorCount = 0;
		checkCount = 0;
		testCount = 0;
		errorsAtStart = 0;
		clk = 1'b0;
		reset = 1'b1;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		readAndPost(ADDR_STATUS, 32'h0, waits);
		readAndPost(ADDR_REGS, 32'h0, waits);
		readAndPost(ADDR_IMM, 32'h0, waits);
		readAndPost(ADDR_CLASS, 32'h0, waits);
		finishTest("reset values");

		// Bit 31 alternates so both signs of every immediate form are seen
		for (int k = 0; k < 8; k++)
		begin
			for (int i = 0; i < 4; i++)
			begin
				word = $random(seed);
				word[6:0] = legalOps[k];
				word[31] = i[0];
				decodeOne(word);
			end
		end
		finishTest("legal opcodes");

		for (int i = 0; i < 16; i++)
		begin
			do
				op = $random(seed);
			while (isLegal(op));
			word = $random(seed);
			word[6:0] = op;
			decodeOne(word);
		end
		finishTest("illegal opcodes");

		// Consecutive decodes with all fields different, so stale data shows
		decodeOne({7'h15, 6'd33, 6'd12, 6'd7, OP_ADD});
		decodeOne({7'h6a, 6'd5, 6'd40, 6'd19, OP_STORE});
		decodeOne({7'h41, 6'd28, 6'd9, 6'd3, OP_DBRA});
		decodeOne({7'h02, 6'd63, 6'd1, 6'd44, OP_RTD});
		finishTest("read after write");

		expectError(8'h14, 1'b0);
		expectError(8'hFC, 1'b0);
		expectError(ADDR_STATUS, 1'b1);
		expectError(ADDR_REGS, 1'b1);
		finishTest("error response");

		$display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
		if (errorCount == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire
